// ==== flist.f ====
hw/axi_bus_pkg.sv
hw/mem_bus_pkg.sv
hw/resp_meta_fifo.sv
hw/axi_to_mem.sv
hw/sram_banks.sv
hw/mem_subsystem_top.sv
testbench/tb_mem_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_mem_subsystem -f flist.f; then
  echo "Verilator build failed"
  exit 1
fi

if ! output=$(./obj_dir/Vtb_mem_subsystem); then
  printf '%s\n' "$output"
  echo "Simulation exited with an error status"
  exit 1
fi
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

// ==== testbench/stimulus_input.txt ====
# kind id addr len qos atop strb seed expect (hex, kind W write, R read, A atomic)
# Beat k writes seed+k, expect is the first R data (old word for A, unused for W)
W 1 0040 00 0 00 F 11223344 00000000
R 2 0040 00 0 00 F 00000000 11223344
W 3 0100 07 1 00 F A0000000 00000000
R 4 0100 07 2 00 F 00000000 A0000000
R 5 0108 03 0 00 F 00000000 A0000002
W 6 0200 00 0 00 F CAFEF00D 00000000
W 7 0200 00 3 00 5 00AA00BB 00000000
R 8 0200 00 0 00 F 00000000 CAAAF0BB
W 9 0300 00 0 00 F 00000010 00000000
A A 0300 00 0 20 F 00000005 00000010
R B 0300 00 0 00 F 00000000 00000015
W C 0304 00 0 00 F 12345678 00000000
A D 0304 00 0 30 F 87654321 12345678
R E 0304 00 0 00 F 00000000 87654321
A F 010C 00 2 20 F 00000001 A0000003
R 0 010C 00 0 00 F 00000000 A0000004
W 1 0400 0F 1 00 F 00001000 00000000
R 2 0400 0F 3 00 F 00000000 00001000
W 3 0500 03 0 00 F 50000000 00000000
R 4 0504 01 0 00 F 00000000 50000001

// ==== testbench/tb_mem_subsystem.sv ====
// Testbench for the AXI4 memory subsystem
// - Clock, reset and a file-driven AXI master
// - Random R/B back-pressure
// - Response checks against expected data from the stimulus file
`timescale 1ns/1ps

module tb_mem_subsystem;

  localparam int unsigned TIMEOUT = 200;

  logic                   clk_i;
  logic                   rst_ni;
  axi_bus_pkg::axi_req_t  axi_req;
  axi_bus_pkg::axi_resp_t axi_resp;
  logic                   busy;

  axi_bus_pkg::axi_ax_t   aw;
  axi_bus_pkg::axi_ax_t   ar;
  axi_bus_pkg::axi_w_t    w;
  logic                   aw_valid;
  logic                   w_valid;
  logic                   ar_valid;
  logic                   r_ready;
  logic                   b_ready;

  integer                 seed;
  logic [31:0]            rnd;
  int unsigned            errors;
  int unsigned            checks;
  int unsigned            timeouts;
  logic                   timed_out;

  assign axi_req = '{aw: aw, aw_valid: aw_valid, w: w, w_valid: w_valid,
                     ar: ar, ar_valid: ar_valid, b_ready: b_ready, r_ready: r_ready};

  mem_subsystem_top DUT (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .axi_req_i  (axi_req),
    .axi_resp_o (axi_resp),
    .busy_o     (busy)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Random R/B back-pressure with ready about three quarters of the time
  initial begin
    seed    = 32'h5ba36321;
    r_ready = 1'b0;
    b_ready = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      rnd     = $random(seed);
      r_ready = rnd[0] | rnd[1];
      b_ready = rnd[2] | rnd[3];
    end
  end

  task automatic note_timeout(input string what);
    timeouts++;
    timed_out = 1'b1;
    $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Ready is sampled at the falling edge and the handshake follows at the next rising edge
  task automatic wait_ready(input logic on_w, input string what, output logic aw_rdy);
    int unsigned cycles;
    logic        ready;
    cycles = 0;
    ready  = 1'b0;
    aw_rdy = 1'b0;
    while (!ready && !timed_out) begin
      @(negedge clk_i);
      ready  = on_w ? axi_resp.w_ready : axi_resp.ar_ready;
      aw_rdy = axi_resp.aw_ready;
      cycles++;
      if (!ready && cycles >= TIMEOUT) begin
        note_timeout(what);
      end
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic collect_responses(input logic [3:0] tid, input int unsigned n_r,
                                   input int unsigned n_b, input logic [31:0] exp_first);
    int unsigned got_r;
    int unsigned got_b;
    int unsigned cycles;
    got_r  = 0;
    got_b  = 0;
    cycles = 0;
    while ((got_r < n_r || got_b < n_b) && !timed_out) begin
      @(negedge clk_i);
      cycles++;
      if (axi_resp.r_valid && r_ready) begin
        assert (got_r < n_r) else begin
          errors++;
          $display("An R beat arrived that no request asked for");
        end
        check_value("R id", 32'(axi_resp.r.id), 32'(tid));
        check_value("R data", axi_resp.r.data, exp_first + 32'(got_r));
        check_value("R last", 32'(axi_resp.r.last), 32'(got_r == n_r - 1));
        check_value("R resp", 32'(axi_resp.r.resp), 32'(axi_bus_pkg::RESP_OKAY));
        got_r++;
        cycles = 0;
      end
      if (axi_resp.b_valid && b_ready) begin
        assert (got_b < n_b) else begin
          errors++;
          $display("A B response arrived that no write asked for");
        end
        check_value("B id", 32'(axi_resp.b.id), 32'(tid));
        check_value("B resp", 32'(axi_resp.b.resp), 32'(axi_bus_pkg::RESP_OKAY));
        got_b++;
        cycles = 0;
      end
      if (cycles >= TIMEOUT) begin
        note_timeout("an R or B response");
      end
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic write_burst(input logic [3:0] tid, input logic [15:0] taddr,
                             input logic [7:0] tlen, input logic [3:0] tqos,
                             input logic [5:0] tatop, input logic [3:0] tstrb,
                             input logic [31:0] tseed);
    int   k;
    logic aw_rdy;
    aw = '{id: tid, addr: taddr, len: tlen, burst: axi_bus_pkg::BURST_INCR, qos: tqos,
           atop: axi_bus_pkg::axi_atop_e'(tatop)};
    aw_valid = 1'b1;
    for (k = 0; k <= int'(tlen) && !timed_out; k++) begin
      w       = '{data: tseed + 32'(k), strb: tstrb, last: (k == int'(tlen))};
      w_valid = 1'b1;
      wait_ready(1'b1, "a W handshake", aw_rdy);
      // AW goes only with the first beat of its burst
      check_value("AW ready with W", 32'(aw_rdy), 32'(k == 0));
      aw_valid = 1'b0;
    end
    w_valid = 1'b0;
  endtask

  task automatic read_burst(input logic [3:0] tid, input logic [15:0] taddr,
                            input logic [7:0] tlen, input logic [3:0] tqos);
    logic aw_rdy;
    ar = '{id: tid, addr: taddr, len: tlen, burst: axi_bus_pkg::BURST_INCR, qos: tqos,
           atop: axi_bus_pkg::ATOP_NONE};
    ar_valid = 1'b1;
    wait_ready(1'b0, "an AR handshake", aw_rdy);
    ar_valid = 1'b0;
  endtask

  task automatic wait_idle();
    int unsigned cycles;
    cycles = 0;
    checks++;
    while (!timed_out) begin
      @(negedge clk_i);
      // Nothing is outstanding any more, so any R or B here is a duplicate
      assert (!(axi_resp.r_valid && r_ready) && !(axi_resp.b_valid && b_ready)) else begin
        errors++;
        $display("An R or B response arrived after all traffic had drained");
      end
      if (!busy) begin
        break;
      end
      cycles++;
      if (cycles >= TIMEOUT) begin
        note_timeout("busy_o going low");
      end
    end
  endtask

  initial begin
    int          fd;
    int          n;
    string       line;
    string       kind;
    logic [31:0] v_id, v_addr, v_len, v_qos, v_atop, v_strb, v_seed, v_exp;
    errors    = 0;
    checks    = 0;
    timeouts  = 0;
    timed_out = 1'b0;
    aw        = '0;
    ar        = '0;
    w         = '0;
    aw_valid  = 1'b0;
    w_valid   = 1'b0;
    ar_valid  = 1'b0;
    rst_ni    = 1'b0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    fd = $fopen("testbench/stimulus_input.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("The stimulus file could not be opened");
    end else begin
      while (!timed_out && !$feof(fd)) begin
        n = $fgets(line, fd);
        if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
          continue;
        end
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", kind, v_id, v_addr, v_len,
                    v_qos, v_atop, v_strb, v_seed, v_exp);
        if (n != 9) begin
          errors++;
          $display("A stimulus line could not be parsed: %s", line);
        end else if (kind == "R") begin
          read_burst(v_id[3:0], v_addr[15:0], v_len[7:0], v_qos[3:0]);
          collect_responses(v_id[3:0], v_len + 1, 0, v_exp);
        end else if (kind == "W" || kind == "A") begin
          write_burst(v_id[3:0], v_addr[15:0], v_len[7:0], v_qos[3:0], v_atop[5:0],
                      v_strb[3:0], v_seed);
          // An atomic also returns the old word on R
          collect_responses(v_id[3:0], (kind == "A") ? 1 : 0, 1, v_exp);
        end else begin
          errors++;
          $display("Unknown transaction kind %s in the stimulus file", kind);
        end
      end
      $fclose(fd);
    end

    wait_idle();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== hw/mem_subsystem_top.sv ====
// Memory subsystem top level
// - AXI4 bridge feeding the banked SRAM
`timescale 1ns/1ps

module mem_subsystem_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  axi_bus_pkg::axi_req_t  axi_req_i,
  output axi_bus_pkg::axi_resp_t axi_resp_o,
  output logic                   busy_o
);

  mem_bus_pkg::mem_req_t          mem_req;
  logic                           mem_req_valid;
  logic                           mem_rvalid;
  logic [axi_bus_pkg::DATA_W-1:0] mem_rdata;

  axi_to_mem u_axi_to_mem (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .axi_req_i       (axi_req_i),
    .axi_resp_o      (axi_resp_o),
    .mem_req_o       (mem_req),
    .mem_req_valid_o (mem_req_valid),
    .mem_rvalid_i    (mem_rvalid),
    .mem_rdata_i     (mem_rdata),
    .busy_o          (busy_o)
  );

  sram_banks u_sram_banks (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (mem_req),
    .req_valid_i (mem_req_valid),
    .rvalid_o    (mem_rvalid),
    .rdata_o     (mem_rdata)
  );

endmodule

// ==== hw/sram_banks.sv ====
// Word-interleaved two-bank SRAM
// - Bank chosen by the low word-address bit
// - One-cycle read latency, byte-strobed writes
// - In-place ADD and SWAP that return the old word
`timescale 1ns/1ps

module sram_banks (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  mem_bus_pkg::mem_req_t          req_i,
  input  logic                           req_valid_i,
  output logic                           rvalid_o,
  output logic [axi_bus_pkg::DATA_W-1:0] rdata_o
);

  logic [mem_bus_pkg::BANK_SEL_W-1:0] bank_sel;
  logic [mem_bus_pkg::ROW_W-1:0]      row;
  logic [axi_bus_pkg::DATA_W-1:0]     bank_rd [mem_bus_pkg::NUM_BANKS];
  logic [axi_bus_pkg::DATA_W-1:0]     old_word;
  logic [axi_bus_pkg::DATA_W-1:0]     src_word;
  logic [axi_bus_pkg::DATA_W-1:0]     new_word;

  assign bank_sel = req_i.addr[mem_bus_pkg::BANK_SEL_W-1:0];
  assign row      = req_i.addr[mem_bus_pkg::WORD_ADDR_W-1:mem_bus_pkg::BANK_SEL_W];
  assign old_word = bank_rd[bank_sel];

  // Value to store, then merged under the byte strobes
  always_comb begin
    case (req_i.amo)
      mem_bus_pkg::AMO_ADD:  src_word = old_word + req_i.wdata;
      mem_bus_pkg::AMO_SWAP: src_word = req_i.wdata;
      default:               src_word = req_i.wdata;
    endcase
    new_word = old_word;
    for (int i = 0; i < axi_bus_pkg::STRB_W; i++) begin
      if (req_i.strb[i]) begin
        new_word[8*i +: 8] = src_word[8*i +: 8];
      end
    end
  end

  for (genvar b = 0; b < mem_bus_pkg::NUM_BANKS; b++) begin : g_bank
    logic [axi_bus_pkg::DATA_W-1:0] mem_q [mem_bus_pkg::BANK_WORDS];

    assign bank_rd[b] = mem_q[row];

    always_ff @(posedge clk_i) begin
      if (req_valid_i && req_i.we && (int'(bank_sel) == b)) begin
        mem_q[row] <= new_word;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_valid_i;
    end
  end

  // Old word comes back for reads, writes and atomics alike
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rdata_o <= old_word;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && !req_i.we |-> req_i.amo == mem_bus_pkg::AMO_NONE)
    else $error("Atomic operation without write enable");

endmodule

// ==== hw/axi_to_mem.sv ====
// AXI4 slave to single-word memory bridge
// - INCR burst trackers for AR and AW/W
// - QoS-aware sticky read/write arbiter
// - AXI atomic (ADD, SWAP) to memory AMO mapping
// - Response metadata FIFO and one-entry R/B skid buffer
`timescale 1ns/1ps

module axi_to_mem (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  axi_bus_pkg::axi_req_t          axi_req_i,
  output axi_bus_pkg::axi_resp_t         axi_resp_o,
  output mem_bus_pkg::mem_req_t          mem_req_o,
  output logic                           mem_req_valid_o,
  input  logic                           mem_rvalid_i,
  input  logic [axi_bus_pkg::DATA_W-1:0] mem_rdata_i,
  output logic                           busy_o
);

  typedef struct packed {
    logic [axi_bus_pkg::ADDR_W-1:0] addr;
    logic [axi_bus_pkg::ID_W-1:0]   id;
    logic [3:0]                     qos;
  } trk_t;

  typedef struct packed {
    trk_t trk;
    logic last;
  } beat_t;

  typedef struct packed {
    logic [axi_bus_pkg::DATA_W-1:0] data;
    mem_bus_pkg::resp_meta_t        meta;
  } skid_t;

  logic [7:0]              r_cnt_q, w_cnt_q;
  trk_t                    r_trk_q, w_trk_q;
  beat_t                   rd_beat, wr_beat, cur_beat;
  logic                    rd_valid, wr_valid;
  logic                    rd_go, wr_go;
  logic                    sel, sel_q, lock_q;
  logic                    arb_valid, issue_ok, issue;
  mem_bus_pkg::mem_amo_e   wr_amo;
  mem_bus_pkg::resp_meta_t cur_meta, head_meta;
  logic                    fifo_full, fifo_empty, fifo_pop;
  skid_t                   skid_q;
  logic                    skid_r_q, skid_b_q;
  logic                    skid_busy, skid_done, to_skid;

  // Read tracker, open burst first, else a fresh AR
  always_comb begin
    rd_valid     = axi_req_i.ar_valid;
    rd_beat.trk  = '{addr: axi_req_i.ar.addr, id: axi_req_i.ar.id, qos: axi_req_i.ar.qos};
    rd_beat.last = (axi_req_i.ar.len == 8'd0);
    if (r_cnt_q != 8'd0) begin
      rd_valid     = 1'b1;
      rd_beat.trk  = r_trk_q;
      rd_beat.last = (r_cnt_q == 8'd1);
    end
  end

  // Write tracker, a new burst needs AW and its first W together
  always_comb begin
    wr_valid     = axi_req_i.aw_valid && axi_req_i.w_valid;
    wr_beat.trk  = '{addr: axi_req_i.aw.addr, id: axi_req_i.aw.id, qos: axi_req_i.aw.qos};
    wr_beat.last = (axi_req_i.aw.len == 8'd0);
    if (w_cnt_q != 8'd0) begin
      wr_valid     = axi_req_i.w_valid;
      wr_beat.trk  = w_trk_q;
      wr_beat.last = (w_cnt_q == 8'd1);
    end
  end

  // Sticky arbiter, sel high picks the write side
  always_comb begin
    sel = sel_q;
    if (!lock_q) begin
      if (rd_valid ^ wr_valid) begin
        sel = wr_valid;
      end else if (rd_valid && wr_valid) begin
        if (wr_beat.trk.qos != rd_beat.trk.qos) begin
          sel = (wr_beat.trk.qos > rd_beat.trk.qos);
        end else if (wr_beat.last && !rd_beat.last && !sel_q) begin
          // Single write slips in only after a read grant
          sel = 1'b1;
        end else if (w_cnt_q != 8'd0) begin
          sel = 1'b1;
        end else if (r_cnt_q != 8'd0) begin
          sel = 1'b0;
        end else begin
          sel = ~sel_q;
        end
      end
    end
  end

  // Atomics are single-beat, so only a burst start carries one
  always_comb begin
    wr_amo = mem_bus_pkg::AMO_NONE;
    if (w_cnt_q == 8'd0) begin
      case (axi_req_i.aw.atop)
        axi_bus_pkg::ATOP_ADD:  wr_amo = mem_bus_pkg::AMO_ADD;
        axi_bus_pkg::ATOP_SWAP: wr_amo = mem_bus_pkg::AMO_SWAP;
        default:                wr_amo = mem_bus_pkg::AMO_NONE;
      endcase
    end
  end

  // The skid slot must be empty when the memory answers
  assign to_skid   = mem_rvalid_i && (head_meta.send_r || head_meta.send_b);
  assign skid_busy = skid_r_q || skid_b_q;
  assign skid_done = skid_busy && !(skid_r_q && !axi_req_i.r_ready)
                               && !(skid_b_q && !axi_req_i.b_ready);
  assign fifo_pop  = skid_done || (mem_rvalid_i && !to_skid);
  assign issue_ok  = !fifo_full && (!skid_busy || skid_done) && !to_skid;

  assign arb_valid       = sel ? wr_valid : rd_valid;
  assign issue           = arb_valid && issue_ok;
  assign rd_go           = issue && !sel;
  assign wr_go           = issue && sel;
  assign mem_req_valid_o = issue;

  always_comb begin
    cur_beat        = sel ? wr_beat : rd_beat;
    mem_req_o.addr  = cur_beat.trk.addr[mem_bus_pkg::WORD_ADDR_W + axi_bus_pkg::BYTE_OFF_W - 1:
                                        axi_bus_pkg::BYTE_OFF_W];
    mem_req_o.wdata = axi_req_i.w.data;
    mem_req_o.strb  = axi_req_i.w.strb;
    mem_req_o.we    = sel;
    mem_req_o.amo   = sel ? wr_amo : mem_bus_pkg::AMO_NONE;
    cur_meta.id     = cur_beat.trk.id;
    cur_meta.last   = cur_beat.last;
    cur_meta.send_b = sel && cur_beat.last;
    cur_meta.send_r = !sel || (wr_amo != mem_bus_pkg::AMO_NONE);
  end

  resp_meta_fifo u_meta_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (issue),
    .data_i  (cur_meta),
    .full_o  (fifo_full),
    .pop_i   (fifo_pop),
    .data_o  (head_meta),
    .empty_o (fifo_empty)
  );

  always_comb begin
    axi_resp_o.ar_ready = rd_go && (r_cnt_q == 8'd0);
    axi_resp_o.aw_ready = wr_go && (w_cnt_q == 8'd0);
    axi_resp_o.w_ready  = wr_go;
    axi_resp_o.r_valid  = skid_r_q;
    axi_resp_o.r        = '{id: skid_q.meta.id, data: skid_q.data,
                            resp: axi_bus_pkg::RESP_OKAY, last: skid_q.meta.last};
    axi_resp_o.b_valid  = skid_b_q;
    axi_resp_o.b        = '{id: skid_q.meta.id, resp: axi_bus_pkg::RESP_OKAY};
  end

  assign busy_o = axi_req_i.ar_valid || axi_req_i.aw_valid || axi_req_i.w_valid ||
                  (r_cnt_q != 8'd0) || (w_cnt_q != 8'd0) || !fifo_empty || skid_busy;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_cnt_q  <= 8'd0;
      w_cnt_q  <= 8'd0;
      sel_q    <= 1'b0;
      lock_q   <= 1'b0;
      skid_r_q <= 1'b0;
      skid_b_q <= 1'b0;
    end else begin
      sel_q  <= sel;
      lock_q <= arb_valid && !issue_ok;
      if (rd_go) begin
        r_cnt_q <= (r_cnt_q != 8'd0) ? r_cnt_q - 8'd1 : axi_req_i.ar.len;
      end
      if (wr_go) begin
        w_cnt_q <= (w_cnt_q != 8'd0) ? w_cnt_q - 8'd1 : axi_req_i.aw.len;
      end
      if (to_skid) begin
        skid_r_q <= head_meta.send_r;
        skid_b_q <= head_meta.send_b;
      end else begin
        if (skid_r_q && axi_req_i.r_ready) begin
          skid_r_q <= 1'b0;
        end
        if (skid_b_q && axi_req_i.b_ready) begin
          skid_b_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_go) begin
      r_trk_q      <= rd_beat.trk;
      r_trk_q.addr <= rd_beat.trk.addr + axi_bus_pkg::BEAT_BYTES;
    end
    if (wr_go) begin
      w_trk_q      <= wr_beat.trk;
      w_trk_q.addr <= wr_beat.trk.addr + axi_bus_pkg::BEAT_BYTES;
    end
    if (to_skid) begin
      skid_q <= '{data: mem_rdata_i, meta: head_meta};
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_resp_o.r_valid && !axi_req_i.r_ready |=> axi_resp_o.r_valid && $stable(axi_resp_o.r))
    else $error("R changed while stalled");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_resp_o.b_valid && !axi_req_i.b_ready |=> axi_resp_o.b_valid && $stable(axi_resp_o.b))
    else $error("B changed while stalled");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (axi_req_i.ar_valid && axi_req_i.ar.len != 8'd0 |-> axi_req_i.ar.burst == axi_bus_pkg::BURST_INCR)
    and (axi_req_i.aw_valid && axi_req_i.aw.len != 8'd0
         |-> axi_req_i.aw.burst == axi_bus_pkg::BURST_INCR))
    else $error("Non-INCR burst is not supported");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_req_i.ar_valid |-> axi_req_i.ar.atop == axi_bus_pkg::ATOP_NONE)
    else $error("Atomic operation on a read");

endmodule

// ==== hw/resp_meta_fifo.sv ====
// Two-entry FIFO for response metadata of requests in flight
// - Separate read and write pointers with an occupancy count
`timescale 1ns/1ps

module resp_meta_fifo (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    push_i,
  input  mem_bus_pkg::resp_meta_t data_i,
  output logic                    full_o,
  input  logic                    pop_i,
  output mem_bus_pkg::resp_meta_t data_o,
  output logic                    empty_o
);

  mem_bus_pkg::resp_meta_t entry_q [2];
  logic                    wr_ptr_q;
  logic                    rd_ptr_q;
  logic [1:0]              count_q;

  assign data_o  = entry_q[rd_ptr_q];
  assign full_o  = (count_q == 2'd2);
  assign empty_o = (count_q == 2'd0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop_i) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      entry_q[wr_ptr_q] <= data_i;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_i && full_o))
    else $error("Metadata FIFO overflow");
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(pop_i && empty_o))
    else $error("Metadata FIFO underflow");

endmodule

// ==== hw/mem_bus_pkg.sv ====
// Memory-side definitions
// - Bank geometry and word address width
// - Atomic memory operation codes
// - Memory request and response metadata structs
package mem_bus_pkg;

  localparam int unsigned NUM_BANKS   = 2;
  localparam int unsigned BANK_WORDS  = 256;
  localparam int unsigned BANK_SEL_W  = $clog2(NUM_BANKS);
  localparam int unsigned ROW_W       = $clog2(BANK_WORDS);
  localparam int unsigned WORD_ADDR_W = BANK_SEL_W + ROW_W;

  typedef enum logic [1:0] {
    AMO_NONE = 2'd0,
    AMO_ADD  = 2'd1,
    AMO_SWAP = 2'd2
  } mem_amo_e;

  typedef struct packed {
    logic [WORD_ADDR_W-1:0]         addr;
    logic [axi_bus_pkg::DATA_W-1:0] wdata;
    logic [axi_bus_pkg::STRB_W-1:0] strb;
    logic                           we;
    mem_amo_e                       amo;
  } mem_req_t;

  // What to send back once the memory answers
  typedef struct packed {
    logic [axi_bus_pkg::ID_W-1:0] id;
    logic                         last;
    logic                         send_b;
    logic                         send_r;
  } resp_meta_t;

endpackage

// ==== hw/axi_bus_pkg.sv ====
// AXI4 bus definitions
// - Address, data and ID widths, beat size
// - Burst, response and atomic-operation enums
// - Channel payload structs and master/slave bundles
package axi_bus_pkg;

  localparam int unsigned ADDR_W     = 16;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned ID_W       = 4;
  localparam int unsigned STRB_W     = DATA_W / 8;
  localparam int unsigned BYTE_OFF_W = $clog2(STRB_W);
  // Address step between two full-word beats
  localparam logic [ADDR_W-1:0] BEAT_BYTES = ADDR_W'(STRB_W);

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // AtomicLoad ADD (little endian) and AtomicSwap
  typedef enum logic [5:0] {
    ATOP_NONE = 6'b00_0000,
    ATOP_ADD  = 6'b10_0000,
    ATOP_SWAP = 6'b11_0000
  } axi_atop_e;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    axi_burst_e        burst;
    logic [3:0]        qos;
    axi_atop_e         atop;
  } axi_ax_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } axi_w_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    axi_resp_e         resp;
    logic              last;
  } axi_r_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    axi_resp_e       resp;
  } axi_b_t;

  typedef struct packed {
    axi_ax_t aw;
    logic    aw_valid;
    axi_w_t  w;
    logic    w_valid;
    axi_ax_t ar;
    logic    ar_valid;
    logic    b_ready;
    logic    r_ready;
  } axi_req_t;

  typedef struct packed {
    logic   aw_ready;
    logic   w_ready;
    logic   ar_ready;
    axi_r_t r;
    logic   r_valid;
    axi_b_t b;
    logic   b_valid;
  } axi_resp_t;

endpackage
